// ==== vlog.f ====
+incdir+hdl
hdl/fetch_pkg.sv
hdl/icache_refill_if.sv
hdl/pc_gen.sv
hdl/branch_predictor.sv
hdl/icache.sv
hdl/icache_ctrl.sv
hdl/fetch_stage.sv
test/tb_mem_model.sv
test/tb_fetch_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fetch_stage
RTL_TOP   ?= fetch_stage
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/tb_fetch_stage.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"
module tb_fetch_stage import fetch_pkg::*; ();

    localparam word_t BR_PC = `FETCH_RESET_PC + 32'h20;
    localparam word_t NOP   = `FETCH_NOP;

    logic  clk_i = 1'b0;
    logic  rst_n_i = 1'b0;
    logic  stall_i;
    logic  mispredict_i;
    logic  jal_valid_i;
    logic  upd_valid_i;
    logic  upd_taken_i;
    word_t upd_pc_i;
    word_t upd_target_i;
    word_t jal_target_i;
    word_t pc_o;
    word_t instr_o;
    word_t mem_addr_o;
    logic  pred_taken_o;
    logic  mem_req_o;
    logic  mem_ready_i;
    logic  mem_valid_i;
    line_t mem_block_i;

    word_t last_pc;
    word_t last_instr;
    word_t exp_pc;
    word_t br_target;
    logic  last_pred;
    logic  hold_chk;
    logic  redir_seen;
    logic  exp_pred;
    logic  addr_chk;
    logic  [27:0] line_tag [16];
    logic  line_ok [16];
    int    errors;
    int    checks;
    int    n_out;
    int    n_branch;
    int    low_reqs;
    logic  [31:0] seed;
    string test_name;

    always #2 clk_i = ~clk_i;

    fetch_stage u_fetch_stage (.*);

    tb_mem_model u_mem (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (mem_req_o),
        .addr_i  (mem_addr_o),
        .ready_o (mem_ready_i),
        .valid_o (mem_valid_i),
        .block_o (mem_block_i)
    );

    function automatic word_t mem_word(input word_t addr);
        if (addr == BR_PC) return {addr[15:2], 11'b0, BRANCH};
        return {addr[15:2], 11'b0, OP_IMM};
    endfunction

    // Expected address after an output at pc
    function automatic word_t next_pc(input word_t pc);
        return (pc == BR_PC && exp_pred) ? br_target : pc + 32'd4;
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t rand_target();
        seed = lcg_next(seed);
        return 32'h1000 | {20'h0, seed[21:12], 2'b00};
    endfunction

    task automatic report(input word_t exp, input word_t act);
        errors++;
        $display("ERR %s expected %h actual %h", test_name, exp, act);
    endtask

    // Checker sampled on the falling edge
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            if (hold_chk && !redir_seen) begin
                checks++;
                if (pc_o != last_pc || instr_o != last_instr || pred_taken_o != last_pred) begin
                    errors++;
                    $display("%s: outputs changed during stall at pc %h", test_name, pc_o);
                end
            end else if (instr_o != NOP && (pc_o != last_pc || last_instr == NOP)) begin
                checks += 3;
                n_out++;
                if (pc_o == BR_PC) n_branch++;
                if (pc_o != exp_pc) report(exp_pc, pc_o);
                if (instr_o != mem_word(pc_o)) report(mem_word(pc_o), instr_o);
                if (pred_taken_o != (pc_o == BR_PC && exp_pred))
                    report(word_t'(pc_o == BR_PC && exp_pred), word_t'(pred_taken_o));
                exp_pc = next_pc(pc_o);
            end
            if (mem_req_o) begin
                checks++;
                if (line_ok[mem_addr_o[7:4]] &&
                    line_tag[mem_addr_o[7:4]] == mem_addr_o[31:4]) begin
                    errors++;
                    $display("%s: refill requested for cached line %h", test_name, mem_addr_o);
                end
                if (mem_addr_o[3:0] != 4'h0) report({mem_addr_o[31:4], 4'h0}, mem_addr_o);
                if (addr_chk && mem_addr_o[31:4] != exp_pc[31:4])
                    report({exp_pc[31:4], 4'h0}, mem_addr_o);
                if (mem_addr_o < 32'h1060) low_reqs++;
                line_ok[mem_addr_o[7:4]]  = 1'b1;
                line_tag[mem_addr_o[7:4]] = mem_addr_o[31:4];
            end
            last_pc    = pc_o;
            last_instr = instr_o;
            last_pred  = pred_taken_o;
            hold_chk   = stall_i;
            redir_seen = mispredict_i || jal_valid_i;
        end
    end

    task automatic wait_outputs(input int n);
        int start;
        int cyc;
        start = n_out;
        cyc = 0;
        while (n_out < start + n && cyc < 3000) begin
            @(posedge clk_i);
            cyc++;
        end
        if (n_out < start + n) begin
            errors++;
            $display("%s: timed out waiting for fetch outputs", test_name);
        end
    endtask

    // Kind 0 is a mispredict, 1 a JAL and 2 both at once
    task automatic redirect(input int kind, input word_t t);
        @(posedge clk_i);
        mispredict_i <= (kind != 1);
        jal_valid_i  <= (kind != 0);
        upd_target_i <= t;
        jal_target_i <= (kind == 2) ? t ^ 32'h40 : t;
        @(posedge clk_i);
        mispredict_i <= 1'b0;
        jal_valid_i  <= 1'b0;
        exp_pc = t;
    endtask

    task automatic train(input logic taken);
        repeat (2) begin
            @(posedge clk_i);
            upd_valid_i  <= 1'b1;
            upd_taken_i  <= taken;
            upd_pc_i     <= BR_PC;
            upd_target_i <= br_target;
        end
        @(posedge clk_i);
        upd_valid_i <= 1'b0;
    endtask

    task automatic finish_test();
        $display("test %s finished, errors so far %0d", test_name, errors);
    endtask

    initial begin
        stall_i = 1'b0;
        mispredict_i = 1'b0;
        jal_valid_i = 1'b0;
        upd_valid_i = 1'b0;
        upd_taken_i = 1'b0;
        upd_pc_i = '0;
        upd_target_i = '0;
        jal_target_i = '0;
        errors = 0;
        checks = 0;
        n_out = 0;
        n_branch = 0;
        low_reqs = 0;
        hold_chk = 1'b0;
        redir_seen = 1'b0;
        exp_pred = 1'b0;
        addr_chk = 1'b1;
        last_pc = '0;
        last_instr = NOP;
        last_pred = 1'b0;
        exp_pc = `FETCH_RESET_PC;
        br_target = 32'h1800;
        seed = 32'hec3923fa;
        for (int i = 0; i < 16; i++) line_ok[i] = 1'b0;
        test_name = "sequential";
        repeat (8) @(posedge clk_i);
        rst_n_i <= 1'b1;
        wait_outputs(24);
        finish_test();

        test_name = "refill";
        redirect(1, `FETCH_RESET_PC);
        wait_outputs(24);
        checks++;
        if (low_reqs != 6) report(6, low_reqs);
        finish_test();

        test_name = "stall";
        for (int i = 0; i < 40; i++) begin
            @(posedge clk_i);
            seed = lcg_next(seed);
            stall_i <= seed[20] & seed[9];   // Stalled about a quarter of the time
        end
        @(posedge clk_i);
        stall_i <= 1'b0;
        wait_outputs(8);
        finish_test();

        test_name = "redirect";
        addr_chk = 1'b0;   // A miss in the redirect cycle still refills the old line
        for (int i = 0; i < 9; i++) begin
            redirect(i % 3, rand_target());
            wait_outputs(3);
        end
        finish_test();

        test_name = "predict";
        @(posedge clk_i);
        stall_i <= 1'b1;
        train(1'b1);
        exp_pred = 1'b1;
        redirect(1, BR_PC - 32'h10);
        @(posedge clk_i);
        stall_i <= 1'b0;
        n_branch = 0;
        wait_outputs(7);
        checks++;
        if (n_branch == 0) begin
            errors++;
            $display("%s: branch at %h was never fetched", test_name, BR_PC);
        end
        @(posedge clk_i);
        stall_i <= 1'b1;
        train(1'b0);
        exp_pred = 1'b0;
        redirect(1, BR_PC - 32'h10);
        @(posedge clk_i);
        stall_i <= 1'b0;
        n_branch = 0;
        wait_outputs(7);
        checks++;
        if (n_branch == 0) begin
            errors++;
            $display("%s: branch at %h was never fetched", test_name, BR_PC);
        end
        finish_test();

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== test/tb_mem_model.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"
module tb_mem_model import fetch_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  req_i,
    input  word_t addr_i,
    output logic  ready_o,
    output logic  valid_o,
    output line_t block_o
);

    localparam int DELAY = 5;

    logic  busy_q;
    int    cnt_q;
    word_t addr_q;

    // OP_IMM image with one BRANCH at reset PC + 0x20
    function automatic word_t image_word(input word_t addr);
        if (addr == `FETCH_RESET_PC + 32'h20) begin
            return {addr[15:2], 11'b0, BRANCH};
        end
        return {addr[15:2], 11'b0, OP_IMM};
    endfunction

    assign ready_o = 1'b1;

    always @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q  <= 1'b0;
            cnt_q   <= 0;
            valid_o <= 1'b0;
            block_o <= '0;
        end else begin
            valid_o <= 1'b0;
            if (req_i) begin
                busy_q <= 1'b1;
                cnt_q  <= 1;
                addr_q <= addr_i;
            end else if (busy_q) begin
                if (cnt_q == DELAY) begin
                    valid_o <= 1'b1;
                    busy_q  <= 1'b0;
                    for (int w = 0; w < 4; w++) begin
                        block_o[32*w +: 32] <= image_word(addr_q + 32'(4 * w));
                    end
                end
                cnt_q <= cnt_q + 1;
            end
        end
    end

endmodule

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"
module fetch_stage import fetch_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  stall_i,

    output word_t pc_o,
    output word_t instr_o,
    output logic  pred_taken_o,

    output logic  mem_req_o,
    output word_t mem_addr_o,
    input  logic  mem_ready_i,
    input  logic  mem_valid_i,
    input  line_t mem_block_i,

    input  logic  upd_valid_i,
    input  logic  upd_taken_i,
    input  word_t upd_pc_i,
    input  word_t upd_target_i,

    input  logic  mispredict_i,
    input  logic  jal_valid_i,
    input  word_t jal_target_i
);

    word_t fetch_pc;
    word_t fetch_word;
    logic  fetch_hit;
    logic  pred_taken;
    word_t pred_target;
    logic  redirect;

    word_t pc_q;
    word_t instr_q;
    logic  pred_taken_q;

    icache_refill_if rf_if ();

    assign redirect = mispredict_i || jal_valid_i;

    pc_gen u_pc_gen (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .stall_i           (stall_i),
        .hit_i             (fetch_hit),
        .mispredict_i      (mispredict_i),
        .redirect_target_i (upd_target_i),   // Correct next PC on a mispredict
        .jal_valid_i       (jal_valid_i),
        .jal_target_i      (jal_target_i),
        .pred_taken_i      (pred_taken),
        .pred_target_i     (pred_target),
        .pc_o              (fetch_pc)
    );

    branch_predictor u_branch_predictor (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .pc_i          (fetch_pc),
        .instr_i       (fetch_word),
        .hit_i         (fetch_hit),
        .upd_valid_i   (upd_valid_i),
        .upd_taken_i   (upd_taken_i),
        .upd_pc_i      (upd_pc_i),
        .upd_target_i  (upd_target_i),
        .pred_taken_o  (pred_taken),
        .pred_target_o (pred_target)
    );

    icache_ctrl u_icache_ctrl (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .pc_i        (fetch_pc),
        .rf          (rf_if.ctrl),
        .hit_o       (fetch_hit),
        .instr_o     (fetch_word),
        .mem_ready_i (mem_ready_i),
        .mem_req_o   (mem_req_o),
        .mem_addr_o  (mem_addr_o),
        .mem_valid_i (mem_valid_i),
        .mem_block_i (mem_block_i)
    );

    icache u_icache (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .rf      (rf_if.cache)
    );

    // Output register to decode
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q         <= `FETCH_RESET_PC;
            instr_q      <= `FETCH_NOP;
            pred_taken_q <= 1'b0;
        end else if (redirect) begin
            instr_q      <= `FETCH_NOP;   // pc_q keeps its value
            pred_taken_q <= 1'b0;
        end else if (!stall_i) begin
            if (fetch_hit) begin
                pc_q         <= fetch_pc;
                instr_q      <= fetch_word;
                pred_taken_q <= pred_taken;
            end else begin
                instr_q      <= `FETCH_NOP;   // Bubble on a miss
                pred_taken_q <= 1'b0;
            end
        end
    end

    assign pc_o         = pc_q;
    assign instr_o      = instr_q;
    assign pred_taken_o = pred_taken_q;

endmodule

// ==== hdl/icache_ctrl.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"
module icache_ctrl import fetch_pkg::*; (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  word_t          pc_i,
    icache_refill_if.ctrl  rf,
    output logic           hit_o,
    output word_t          instr_o,
    input  logic           mem_ready_i,
    output logic           mem_req_o,
    output word_t          mem_addr_o,
    input  logic           mem_valid_i,
    input  line_t          mem_block_i
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT
    } state_e;

    state_e state_q;
    state_e state_d;
    word_t  miss_addr_q;   // Line-aligned address of the refill

    assign rf.lookup_addr = pc_i;

    // No hits reported while a refill is in flight
    assign hit_o   = rf.hit && (state_q == IDLE);
    assign instr_o = rf.rd_word;

    assign mem_req_o  = (state_q == REQ) && mem_ready_i;
    assign mem_addr_o = miss_addr_q;

    assign rf.fill_valid = (state_q == WAIT) && mem_valid_i;
    assign rf.fill_addr  = miss_addr_q;
    assign rf.fill_line  = mem_block_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: if (!rf.hit) state_d = REQ;
            REQ:  if (mem_ready_i) state_d = WAIT;
            WAIT: if (mem_valid_i) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Latched on the miss so a redirect cannot move the refill
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && !rf.hit) begin
            miss_addr_q <= {pc_i[31:`IC_OFF_W], {`IC_OFF_W{1'b0}}};
        end
    end

endmodule

// ==== hdl/icache.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"
module icache import fetch_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_n_i,
    icache_refill_if.cache  rf
);

    localparam int IDX_W = `IC_IDX_W;
    localparam int OFF_W = `IC_OFF_W;
    localparam int TAG_W = 32 - IDX_W - OFF_W;

    logic             valid_q [`IC_LINES];
    logic [TAG_W-1:0] tag_q   [`IC_LINES];
    line_t            data_q  [`IC_LINES];

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [1:0]       rd_sel;
    logic [IDX_W-1:0] wr_idx;
    line_t            rd_line;

    assign rd_idx = rf.lookup_addr[OFF_W+IDX_W-1:OFF_W];
    assign rd_tag = rf.lookup_addr[31:OFF_W+IDX_W];
    assign rd_sel = rf.lookup_addr[3:2];
    assign wr_idx = rf.fill_addr[OFF_W+IDX_W-1:OFF_W];

    // Combinational lookup
    assign rd_line    = data_q[rd_idx];
    assign rf.hit     = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign rf.rd_word = rd_line[32*rd_sel +: 32];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `IC_LINES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (rf.fill_valid) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rf.fill_valid) begin
            tag_q[wr_idx]  <= rf.fill_addr[31:OFF_W+IDX_W];
            data_q[wr_idx] <= rf.fill_line;
        end
    end

endmodule

// ==== hdl/branch_predictor.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"
module branch_predictor import fetch_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  word_t pc_i,
    input  word_t instr_i,
    input  logic  hit_i,
    input  logic  upd_valid_i,
    input  logic  upd_taken_i,
    input  word_t upd_pc_i,
    input  word_t upd_target_i,
    output logic  pred_taken_o,
    output word_t pred_target_o
);

    localparam int IDX_W = `BP_IDX_W;
    localparam int TAG_W = 30 - IDX_W;   // Upper PC bits above the index

    ctr_t             ctr_q        [`BP_ENTRIES];
    logic             btb_valid_q  [`BP_ENTRIES];
    logic [TAG_W-1:0] btb_tag_q    [`BP_ENTRIES];
    word_t            btb_target_q [`BP_ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] upd_idx;
    logic             is_branch;
    logic             btb_match;

    assign rd_idx  = pc_i[IDX_W+1:2];
    assign upd_idx = upd_pc_i[IDX_W+1:2];

    // Pre-decode
    assign is_branch = (opcode_e'(instr_i[6:0]) == BRANCH);
    assign btb_match = btb_valid_q[rd_idx] && (btb_tag_q[rd_idx] == pc_i[31:IDX_W+2]);

    assign pred_taken_o  = is_branch && hit_i && ctr_q[rd_idx][1] && btb_match;
    assign pred_target_o = btb_target_q[rd_idx];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `BP_ENTRIES; i++) begin
                ctr_q[i]       <= 2'b01;   // Weakly not taken
                btb_valid_q[i] <= 1'b0;
            end
        end else if (upd_valid_i) begin
            if (upd_taken_i) begin
                btb_valid_q[upd_idx] <= 1'b1;
                if (ctr_q[upd_idx] != 2'b11) begin
                    ctr_q[upd_idx] <= ctr_q[upd_idx] + 2'd1;
                end
            end else if (ctr_q[upd_idx] != 2'b00) begin
                ctr_q[upd_idx] <= ctr_q[upd_idx] - 2'd1;
            end
        end
    end

    // Target and tag written on taken updates only
    always_ff @(posedge clk_i) begin
        if (upd_valid_i && upd_taken_i) begin
            btb_tag_q[upd_idx]    <= upd_pc_i[31:IDX_W+2];
            btb_target_q[upd_idx] <= upd_target_i;
        end
    end

endmodule

// ==== hdl/pc_gen.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"
module pc_gen import fetch_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  stall_i,
    input  logic  hit_i,
    input  logic  mispredict_i,
    input  word_t redirect_target_i,
    input  logic  jal_valid_i,
    input  word_t jal_target_i,
    input  logic  pred_taken_i,
    input  word_t pred_target_i,
    output word_t pc_o
);

    word_t pc_q;
    word_t pc_d;
    word_t pc_plus4;

    assign pc_plus4 = pc_q + 32'd4;

    // Redirects beat stall, stall and miss beat prediction
    always_comb begin
        if (mispredict_i) begin
            pc_d = redirect_target_i;
        end else if (jal_valid_i) begin
            pc_d = jal_target_i;
        end else if (stall_i || !hit_i) begin
            pc_d = pc_q;
        end else if (pred_taken_i) begin
            pc_d = pred_target_i;
        end else begin
            pc_d = pc_plus4;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= `FETCH_RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;

endmodule

// ==== hdl/icache_refill_if.sv ====
`timescale 1ns/1ps
interface icache_refill_if import fetch_pkg::*; ();

    word_t lookup_addr;
    logic  hit;
    word_t rd_word;

    logic  fill_valid;   // One-cycle write strobe
    word_t fill_addr;
    line_t fill_line;

    modport ctrl (
        output lookup_addr,
        input  hit,
        input  rd_word,
        output fill_valid,
        output fill_addr,
        output fill_line
    );

    modport cache (
        input  lookup_addr,
        output hit,
        output rd_word,
        input  fill_valid,
        input  fill_addr,
        input  fill_line
    );

endinterface

// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

    // Address or instruction word
    typedef logic [31:0] word_t;

    // Cache line with word 0 in the low bits
    typedef logic [127:0] line_t;

    // Saturating counter that predicts taken from 2 up
    typedef logic [1:0] ctr_t;

    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

endpackage

// ==== hdl/fetch_cfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

`define FETCH_RESET_PC 32'h0000_1000
`define FETCH_NOP      32'h0000_0013   // addi x0, x0, 0

// Instruction cache of 16 lines of 128 bits
`define IC_LINES       16
`define IC_IDX_W       4
`define IC_OFF_W       4

// Branch predictor indexed by pc[5:2]
`define BP_ENTRIES     16
`define BP_IDX_W       4

`endif
